// File: crypto_top.f
crypto_pkg.sv
crypto_regs.sv
crypto_seq.sv
block_fifo.sv
xor_engine.sv
crypto_top.sv
tb_crypto_top.sv

// File: run.sh
#!/bin/sh
# Compile and run the crypto shell testbench with Verilator.
# The exit status of the simulation binary is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f crypto_top.f \
    --top-module tb_crypto_top \
    -o tb_crypto_top

./obj_dir/tb_crypto_top

// File: tb_crypto_top.sv
// Testbench for the crypto shell top level.
// Inputs change on the falling clock edge and outputs are sampled 3 time
// units later, one unit before the rising edge that acts on them.
// Expected output blocks come from a reference XOR and are checked in order.
// The first error ends the run through $fatal.

`default_nettype none

module tb_crypto_top;

    import crypto_pkg::*;

    logic     crypto_clk;
    logic     crypto_rstn;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    blk_t     s_blk;
    logic     s_valid;
    logic     s_ready;
    blk_t     m_blk;
    logic     m_valid;
    logic     m_ready;
    logic     crypto_intr;

    logic        rand_ready;
    logic [127:0] key_val;
    logic [31:0] last_exp_word;
    logic [31:0] rd;
    logic        err;
    blk_t        exp_q[$];
    blk_t        exp_blk;

    crypto_top #(.in_depth(4), .out_depth(4)) dut (
        .crypto_clk  (crypto_clk),
        .crypto_rstn (crypto_rstn),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .s_blk       (s_blk),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .m_blk       (m_blk),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .crypto_intr (crypto_intr)
    );

    always #4 crypto_clk = ~crypto_clk;

    // --------------------------------------------------
    // Reference model and checks
    // --------------------------------------------------
    function automatic logic [127:0] xor_ref(input logic [127:0] data, input logic [127:0] key);
        return data ^ key;
    endfunction

    function automatic logic [127:0] rand_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [127:0] exp,
                               input logic [127:0] got);
        if (exp !== got) begin
            abort_run($sformatf("FAIL %s exp %0h got %0h", name, exp, got));
        end
    endtask

    // Output monitor, compares accepted blocks in order
    always begin
        @(negedge crypto_clk);
        #3;
        if (crypto_rstn && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("An output block appeared when none was expected");
            end else begin
                exp_blk = exp_q.pop_front();
                check_equal("m_blk.data", exp_blk.data, m_blk.data);
                check_equal("m_blk.last", 128'(exp_blk.last), 128'(m_blk.last));
            end
        end
    end

    // Output back-pressure
    always begin
        @(negedge crypto_clk);
        if (rand_ready) begin
            m_ready = ($urandom_range(1, 0) != 0);
        end else begin
            m_ready = 1'b1;
        end
    end

    // --------------------------------------------------
    // APB and stream drivers
    // --------------------------------------------------
    task automatic apb_access(input logic [11:0] addr, input logic write,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        int waited;
        @(negedge crypto_clk);
        apb_req.addr   = addr;
        apb_req.wdata  = wdata;
        apb_req.write  = write;
        apb_req.sel    = 1'b1;
        apb_req.enable = 1'b0;
        @(negedge crypto_clk);
        apb_req.enable = 1'b1;
        waited = 0;
        #2;
        while (!apb_rsp.ready) begin
            waited++;
            if (waited > 16) begin
                abort_run("Timeout waiting for APB ready");
            end
            @(negedge crypto_clk);
            #2;
        end
        rdata  = apb_rsp.rdata;
        slverr = apb_rsp.slverr;
        @(negedge crypto_clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused_rd;
        logic        slverr;
        apb_access(addr, 1'b1, data, unused_rd, slverr);
        check_equal("apb_rsp.slverr", '0, 128'(slverr));
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        logic slverr;
        apb_access(addr, 1'b0, '0, data, slverr);
        check_equal("apb_rsp.slverr", '0, 128'(slverr));
    endtask

    task automatic write_key(input logic [127:0] key);
        apb_write(reg_key0, key[31:0]);
        apb_write(reg_key1, key[63:32]);
        apb_write(reg_key2, key[95:64]);
        apb_write(reg_key3, key[127:96]);
    endtask

    task automatic send_blocks(input int count);
        blk_t blk;
        blk_t exp;
        int   waited;
        for (int i = 0; i < count; i++) begin
            blk.data = rand_block();
            blk.last = (i == count - 1);
            exp.data = xor_ref(blk.data, key_val);
            exp.last = blk.last;
            exp_q.push_back(exp);
            last_exp_word = exp.data[31:0];
            @(negedge crypto_clk);
            s_blk   = blk;
            s_valid = 1'b1;
            waited  = 0;
            #3;
            while (!s_ready) begin
                waited++;
                if (waited > 200) begin
                    abort_run("Timeout waiting for s_ready on the input stream");
                end
                @(negedge crypto_clk);
                #3;
            end
        end
        @(negedge crypto_clk);
        s_valid = 1'b0;
    endtask

    task automatic wait_done(output logic [31:0] status);
        int tries;
        tries = 0;
        apb_read(reg_status, status);
        while (!status[31]) begin
            tries++;
            if (tries > 100) begin
                abort_run("Timeout waiting for STATUS done");
            end
            apb_read(reg_status, status);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > 500) begin
                abort_run("Timeout waiting for expected output blocks");
            end
            @(negedge crypto_clk);
        end
    endtask

    task automatic wait_intr(input logic level);
        int waited;
        waited = 0;
        #3;
        while (crypto_intr !== level) begin
            waited++;
            if (waited > 50) begin
                abort_run("Timeout waiting for crypto_intr to change");
            end
            @(negedge crypto_clk);
            #3;
        end
    endtask

    task automatic run_xor_op(input int count);
        key_val = rand_block();
        write_key(key_val);
        apb_write(reg_algo, 32'h0);
        apb_write(reg_start, 32'h1);
        send_blocks(count);
        wait_done(rd);
        wait_drain();
        check_equal("STATUS", 128'h8000_0000, 128'(rd));
        apb_read(reg_result, rd);
        check_equal("RESULT", 128'(last_exp_word), 128'(rd));
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(36734));
        crypto_clk  = 1'b0;
        crypto_rstn = 1'b0;
        apb_req     = '0;
        s_blk       = '0;
        s_valid     = 1'b0;
        m_ready     = 1'b0;
        rand_ready  = 1'b0;
        repeat (16) @(negedge crypto_clk);
        crypto_rstn = 1'b1;

        // Reset values
        apb_read(reg_status, rd);
        check_equal("STATUS", '0, 128'(rd));
        #3;
        check_equal("crypto_intr", '0, 128'(crypto_intr));
        check_equal("s_ready", '0, 128'(s_ready));

        // XOR operation, then the same under random back-pressure
        run_xor_op(6);
        rand_ready = 1'b1;
        run_xor_op(6);
        rand_ready = 1'b0;

        // Unsupported algorithm
        apb_write(reg_algo, 32'h5);
        apb_write(reg_start, 32'h1);
        @(negedge crypto_clk);
        s_blk.data = rand_block();
        s_blk.last = 1'b1;
        s_valid    = 1'b1;
        for (int i = 0; i < 20; i++) begin
            #3;
            check_equal("s_ready", '0, 128'(s_ready));
            @(negedge crypto_clk);
        end
        wait_done(rd);
        s_valid = 1'b0;
        check_equal("STATUS", 128'hC000_0000, 128'(rd));

        // Interrupt raised by done, cleared by the next start
        apb_write(reg_algo, 32'h0);
        apb_write(reg_start, 32'h1);
        apb_write(reg_ctrl, 32'h1);
        #3;
        check_equal("crypto_intr", '0, 128'(crypto_intr));
        send_blocks(2);
        wait_done(rd);
        wait_drain();
        wait_intr(1'b1);
        apb_write(reg_start, 32'h1);
        wait_intr(1'b0);
        send_blocks(1);
        wait_done(rd);
        wait_drain();
        apb_write(reg_ctrl, 32'h0);

        // Unmapped offset and register readback
        apb_access(12'h200, 1'b1, 32'hDEAD_BEEF, rd, err);
        check_equal("apb_rsp.slverr", 128'd1, 128'(err));
        apb_access(12'h200, 1'b0, '0, rd, err);
        check_equal("apb_rsp.slverr", 128'd1, 128'(err));
        check_equal("apb_rsp.rdata", '0, 128'(rd));
        apb_write(reg_ctrl, 32'h1);
        apb_read(reg_ctrl, rd);
        check_equal("CTRL", 128'h1, 128'(rd));
        apb_write(reg_algo, 32'hA);
        apb_read(reg_algo, rd);
        check_equal("ALGO", 128'hA, 128'(rd));
        key_val[31:0] = $urandom;
        apb_write(reg_key0, key_val[31:0]);
        apb_read(reg_key0, rd);
        check_equal("KEY0", 128'(key_val[31:0]), 128'(rd));

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: crypto_top.sv
// Crypto shell top level on a single clock domain.
// APB registers, dispatch sequencer, input FIFO, XOR engine, output FIFO.
// Stream transfers happen when valid and ready are both high.
// FIFO depths are set here and passed down.

`default_nettype none

module crypto_top #(
    parameter int in_depth  = 4,
    parameter int out_depth = 4
) (
    input  wire logic                 crypto_clk,
    input  wire logic                 crypto_rstn,
    input  wire crypto_pkg::apb_req_t apb_req,
    output crypto_pkg::apb_rsp_t      apb_rsp,
    input  wire crypto_pkg::blk_t     s_blk,
    input  wire logic                 s_valid,
    output logic                      s_ready,
    output crypto_pkg::blk_t          m_blk,
    output logic                      m_valid,
    input  wire logic                 m_ready,
    output logic                      crypto_intr
);

    import crypto_pkg::*;

    logic                 intr_en;
    algo_t                algo;
    logic [key_width-1:0] key;
    logic                 start;
    logic                 busy;
    logic                 done;
    logic                 error;
    logic [31:0]          result_word;

    logic                 in_push;
    logic                 in_full;
    logic                 in_pop;
    logic                 in_empty;
    blk_t                 in_blk;
    logic                 out_push;
    logic                 out_full;
    logic                 out_pop;
    logic                 out_empty;
    blk_t                 eng_blk;
    logic                 last_done;

    crypto_regs u_regs (
        .crypto_clk  (crypto_clk),
        .crypto_rstn (crypto_rstn),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .busy        (busy),
        .done        (done),
        .error       (error),
        .result_word (result_word),
        .intr_en     (intr_en),
        .algo        (algo),
        .key         (key),
        .start       (start)
    );

    crypto_seq u_seq (
        .crypto_clk  (crypto_clk),
        .crypto_rstn (crypto_rstn),
        .start       (start),
        .algo        (algo),
        .intr_en     (intr_en),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .s_last      (s_blk.last),
        .push        (in_push),
        .fifo_full   (in_full),
        .last_done   (last_done),
        .busy        (busy),
        .done        (done),
        .error       (error),
        .crypto_intr (crypto_intr)
    );

    block_fifo #(.depth(in_depth), .payload_t(blk_t)) in_fifo (
        .crypto_clk  (crypto_clk),
        .crypto_rstn (crypto_rstn),
        .push        (in_push),
        .wr_data     (s_blk),
        .full        (in_full),
        .pop         (in_pop),
        .rd_data     (in_blk),
        .empty       (in_empty)
    );

    xor_engine u_engine (
        .crypto_clk  (crypto_clk),
        .crypto_rstn (crypto_rstn),
        .key         (key),
        .in_blk      (in_blk),
        .in_empty    (in_empty),
        .in_pop      (in_pop),
        .out_blk     (eng_blk),
        .out_full    (out_full),
        .out_push    (out_push),
        .last_done   (last_done),
        .result_word (result_word)
    );

    block_fifo #(.depth(out_depth), .payload_t(blk_t)) out_fifo (
        .crypto_clk  (crypto_clk),
        .crypto_rstn (crypto_rstn),
        .push        (out_push),
        .wr_data     (eng_blk),
        .full        (out_full),
        .pop         (out_pop),
        .rd_data     (m_blk),
        .empty       (out_empty)
    );

    // Output stream handshake
    assign m_valid = !out_empty;
    assign out_pop = m_valid && m_ready;

endmodule

`default_nettype wire

// File: xor_engine.sv
// Stand-in block engine that XORs each block with the key and keeps its last flag.
// One register stage, so a block is pushed exactly one cycle after its pop.
// Only one block is in flight at a time; this keeps the output FIFO from
// overflowing with only a full flag to go on, at half the peak throughput.

`default_nettype none

module xor_engine (
    input  wire logic                          crypto_clk,
    input  wire logic                          crypto_rstn,
    input  wire logic [crypto_pkg::key_width-1:0] key,
    input  wire crypto_pkg::blk_t              in_blk,
    input  wire logic                          in_empty,
    output logic                               in_pop,
    output crypto_pkg::blk_t                   out_blk,
    input  wire logic                          out_full,
    output logic                               out_push,
    output logic                               last_done,
    output logic [31:0]                        result_word
);

    import crypto_pkg::*;

    blk_t stage_blk;
    logic stage_valid;

    // Pop only while the stage is empty
    assign in_pop = !in_empty && !out_full && !stage_valid;

    always_ff @(posedge crypto_clk or negedge crypto_rstn) begin
        if (!crypto_rstn) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_pop;
        end
    end

    always_ff @(posedge crypto_clk) begin
        if (in_pop) begin
            stage_blk.data <= in_blk.data ^ key;
            stage_blk.last <= in_blk.last;
        end
    end

    assign out_push  = stage_valid;
    assign out_blk   = stage_blk;
    assign last_done = stage_valid && stage_blk.last;

    // Low word of the most recent output block
    always_ff @(posedge crypto_clk or negedge crypto_rstn) begin
        if (!crypto_rstn) begin
            result_word <= '0;
        end else if (out_push) begin
            result_word <= stage_blk.data[31:0];
        end
    end

    // One block in flight leaves room in the output FIFO for every push
    a_push_has_room: assert property (@(posedge crypto_clk) disable iff (!crypto_rstn)
        out_push |-> !out_full);

endmodule

`default_nettype wire

// File: block_fifo.sv
// Synchronous FIFO with first-word fall-through read data.
// rd_data is valid whenever empty is low; pop consumes it.
// Pushing when full or popping when empty is illegal.
// depth need not be a power of two.

`default_nettype none

module block_fifo #(
    parameter int  depth     = 4,
    parameter type payload_t = logic
) (
    input  wire logic     crypto_clk,
    input  wire logic     crypto_rstn,
    input  wire logic     push,
    input  wire payload_t wr_data,
    output logic          full,
    input  wire logic     pop,
    output payload_t      rd_data,
    output logic          empty
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    payload_t      mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [cw-1:0] count;

    function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] ptr);
        if (ptr == aw'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge crypto_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge crypto_clk or negedge crypto_rstn) begin
        if (!crypto_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign rd_data = mem[rd_ptr];
    assign full    = (count == cw'(depth));
    assign empty   = (count == '0);

    a_no_overflow: assert property (@(posedge crypto_clk) disable iff (!crypto_rstn)
        push |-> !full);
    a_no_underflow: assert property (@(posedge crypto_clk) disable iff (!crypto_rstn)
        pop |-> !empty);

endmodule

`default_nettype wire

// File: crypto_seq.sv
// Operation sequencer of the crypto shell.
// Only algo_xor is supported and any other code ends in op_error.
// The input stream is open only in op_run and closes once the block with
// last set has been accepted. Done and error are sticky until the next
// accepted start; a start while busy is ignored.

`default_nettype none

module crypto_seq (
    input  wire logic               crypto_clk,
    input  wire logic               crypto_rstn,
    input  wire logic               start,
    input  wire crypto_pkg::algo_t  algo,
    input  wire logic               intr_en,
    input  wire logic               s_valid,
    output logic                    s_ready,
    input  wire logic               s_last,
    output logic                    push,
    input  wire logic               fifo_full,
    input  wire logic               last_done,
    output logic                    busy,
    output logic                    done,
    output logic                    error,
    output logic                    crypto_intr
);

    import crypto_pkg::*;

    op_state_t state;
    op_state_t state_nxt;
    logic      start_ok;
    logic      last_seen;

    assign start_ok = start && (state == op_idle);

    // --------------------------------------------------
    // Dispatch FSM
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            op_idle: begin
                if (start) begin
                    state_nxt = (algo == algo_xor) ? op_run : op_error;
                end
            end
            op_run: begin
                if (last_done) begin
                    state_nxt = op_done;
                end
            end
            default: begin
                state_nxt = op_idle;
            end
        endcase
    end

    always_ff @(posedge crypto_clk or negedge crypto_rstn) begin
        if (!crypto_rstn) begin
            state <= op_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Input gating
    assign s_ready = (state == op_run) && !fifo_full && !last_seen;
    assign push    = s_valid && s_ready;

    // Sticky status and end-of-stream marker
    always_ff @(posedge crypto_clk or negedge crypto_rstn) begin
        if (!crypto_rstn) begin
            last_seen <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
        end else if (start_ok) begin
            last_seen <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
        end else begin
            if (push && s_last) begin
                last_seen <= 1'b1;
            end
            if (state == op_done || state == op_error) begin
                done <= 1'b1;
            end
            if (state == op_error) begin
                error <= 1'b1;
            end
        end
    end

    assign busy        = (state != op_idle);
    assign crypto_intr = done && intr_en;

    // The engine may only finish a stream that this FSM opened
    a_last_in_run: assert property (@(posedge crypto_clk) disable iff (!crypto_rstn)
        last_done |-> state == op_run);

endmodule

`default_nettype wire

// File: crypto_regs.sv
// APB register bank of the crypto shell.
// Zero wait states: ready is tied high, rdata and slverr are combinational.
// Unmapped offsets answer with slverr and read as 0.
// STATUS and RESULT are read-only; writes to them are dropped silently.
// START produces a one-cycle pulse in the cycle after the write access.

`default_nettype none

module crypto_regs (
    input  wire logic                          crypto_clk,
    input  wire logic                          crypto_rstn,
    input  wire crypto_pkg::apb_req_t          apb_req,
    output crypto_pkg::apb_rsp_t               apb_rsp,
    input  wire logic                          busy,
    input  wire logic                          done,
    input  wire logic                          error,
    input  wire logic [31:0]                   result_word,
    output logic                               intr_en,
    output crypto_pkg::algo_t                  algo,
    output logic [crypto_pkg::key_width-1:0]   key,
    output logic                               start
);

    import crypto_pkg::*;

    logic        access;
    logic        wr_en;
    logic        mapped;
    logic [31:0] rd_word;

    assign access = apb_req.sel && apb_req.enable;
    assign wr_en  = access && apb_req.write;

    // --------------------------------------------------
    // Read decode
    // --------------------------------------------------
    always_comb begin
        mapped  = 1'b1;
        rd_word = '0;
        case (apb_req.addr)
            reg_ctrl: begin
                rd_word = {31'b0, intr_en};
            end
            reg_status: begin
                rd_word = {done, error, 29'b0, busy};
            end
            reg_algo: begin
                rd_word = {28'b0, algo};
            end
            reg_start: begin
                rd_word = '0;
            end
            reg_key0: begin
                rd_word = key[31:0];
            end
            reg_key1: begin
                rd_word = key[63:32];
            end
            reg_key2: begin
                rd_word = key[95:64];
            end
            reg_key3: begin
                rd_word = key[127:96];
            end
            reg_result: begin
                rd_word = result_word;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    always_comb begin
        apb_rsp.rdata  = rd_word;
        apb_rsp.ready  = 1'b1;
        apb_rsp.slverr = access && !mapped;
    end

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    always_ff @(posedge crypto_clk or negedge crypto_rstn) begin
        if (!crypto_rstn) begin
            intr_en <= 1'b0;
            algo    <= algo_xor;
            key     <= '0;
            start   <= 1'b0;
        end else begin
            // Self-clearing, so START always reads back as 0
            start <= wr_en && (apb_req.addr == reg_start) && apb_req.wdata[0];
            if (wr_en) begin
                case (apb_req.addr)
                    reg_ctrl: begin
                        intr_en <= apb_req.wdata[0];
                    end
                    reg_algo: begin
                        algo <= apb_req.wdata[3:0];
                    end
                    reg_key0: begin
                        key[31:0] <= apb_req.wdata;
                    end
                    reg_key1: begin
                        key[63:32] <= apb_req.wdata;
                    end
                    reg_key2: begin
                        key[95:64] <= apb_req.wdata;
                    end
                    reg_key3: begin
                        key[127:96] <= apb_req.wdata;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: crypto_pkg.sv
// Shared widths, codes, register map and bus structs of the crypto shell.
// Only algorithm code 0 (XOR with the key) is implemented; every other
// code is reported as an error by the sequencer.
// Register offsets are byte addresses within a 4 KB APB window.

`default_nettype none

package crypto_pkg;

    // ----------------------------------------------
    // Widths
    // ----------------------------------------------
    localparam int data_width = 128;
    localparam int key_width  = 128;

    // ----------------------------------------------
    // Algorithm codes and sequencer states
    // ----------------------------------------------
    typedef logic [3:0] algo_t;

    localparam algo_t algo_xor = 4'd0;

    typedef enum logic [1:0] {
        op_idle  = 2'd0,
        op_run   = 2'd1,
        op_done  = 2'd2,
        op_error = 2'd3
    } op_state_t;

    // ----------------------------------------------
    // Register offsets
    // ----------------------------------------------
    localparam logic [11:0] reg_ctrl   = 12'h000;
    localparam logic [11:0] reg_status = 12'h004;
    localparam logic [11:0] reg_algo   = 12'h00C;
    localparam logic [11:0] reg_start  = 12'h014;
    localparam logic [11:0] reg_key0   = 12'h040;
    localparam logic [11:0] reg_key1   = 12'h044;
    localparam logic [11:0] reg_key2   = 12'h048;
    localparam logic [11:0] reg_key3   = 12'h04C;
    localparam logic [11:0] reg_result = 12'h100;

    // ----------------------------------------------
    // Stream and bus structs
    // ----------------------------------------------
    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
    } blk_t;

    typedef struct packed {
        logic [11:0] addr;
        logic [31:0] wdata;
        logic        write;
        logic        sel;
        logic        enable;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
        logic        slverr;
    } apb_rsp_t;

endpackage

`default_nettype wire
